//--- logic/evp_config.svh
`ifndef EVP_CONFIG_SVH
`define EVP_CONFIG_SVH

// Polynomial and coefficient table geometry
`define EVP_NUM_POLY   8
`define EVP_POLY_AW    3
`define EVP_NUM_COEF   11
`define EVP_COEF_DEPTH (`EVP_NUM_POLY * `EVP_NUM_COEF)
`define EVP_COEF_AW    7
`define EVP_DEG_W      5

// Sample buffer and data width
`define EVP_X_DEPTH    1024
`define EVP_X_AW       10
`define EVP_DATA_W     16

`endif

//--- logic/evp_status_pkg.sv
package evp_status_pkg;

	localparam logic [31:0] ST_NONE    = 32'hffff_ffff;
	localparam logic [31:0] ST_OK      = 32'h0000_0000;
	localparam logic [31:0] ST_BAD_DEG = 32'h0000_0002;

	// APB register map
	localparam logic [3:0] REG_CMD    = 4'h0;
	localparam logic [3:0] REG_STATUS = 4'h4;
	localparam logic [3:0] REG_RESULT = 4'h8;
	localparam logic [3:0] REG_FLAGS  = 4'hc;

	localparam int FLAG_BUSY = 0;
	localparam int FLAG_DONE = 1;

	typedef struct packed {
		logic [31:0] result;
		logic [31:0] status;
	} res_rec_t;

endpackage

//--- logic/evp_cmd_pkg.sv
`include "evp_config.svh"

package evp_cmd_pkg;

	typedef enum logic [3:0] {
		OP_EVAL = 4'h1,
		OP_LOAD = 4'h2
	} opcode_e;

	typedef enum logic [1:0] {
		TBL_DEG  = 2'd0,
		TBL_COEF = 2'd1,
		TBL_X    = 2'd2
	} table_e;

	// Evaluate layout, opcode in the top nibble
	typedef struct packed {
		logic [3:0] op;
		logic [`EVP_POLY_AW-1:0] poly;
		logic [`EVP_X_AW-1:0] x_addr;
		logic [27-`EVP_POLY_AW-`EVP_X_AW:0] spare;
	} eval_word_t;

	// Load layout, the value sits in the low half
	typedef struct packed {
		logic [3:0] op;
		table_e tsel;
		logic [`EVP_X_AW-1:0] addr;
		logic [`EVP_DATA_W-1:0] value;
	} load_word_t;

	typedef union packed {
		eval_word_t eval;
		load_word_t load;
	} cmd_word_u;

endpackage

//--- logic/evp_ifs.sv
`include "evp_config.svh"

interface evp_cmd_if;
	logic start;
	logic [`EVP_POLY_AW-1:0] poly;
	logic [`EVP_X_AW-1:0] x_addr;
	logic busy;

	modport decode (output start, poly, x_addr, input busy);
	modport execute (input start, poly, x_addr);
	modport result (input start, output busy);
endinterface

interface evp_tbl_if;
	logic en_deg;
	logic [`EVP_POLY_AW-1:0] deg_addr;
	logic [`EVP_DEG_W-1:0] deg;
	logic en_coef;
	logic [`EVP_COEF_AW-1:0] coef_addr;
	logic [`EVP_DATA_W-1:0] coef;
	logic en_x;
	logic [`EVP_X_AW-1:0] x_addr;
	logic [`EVP_DATA_W-1:0] x;

	modport execute (output en_deg, deg_addr, en_coef, coef_addr, en_x, x_addr,
		input deg, coef, x);
	modport tables (input en_deg, deg_addr, en_coef, coef_addr, en_x, x_addr,
		output deg, coef, x);
endinterface

interface evp_res_if;
	logic valid;
	evp_status_pkg::res_rec_t rec;
	logic accepted;
	logic busy_exec;

	modport execute (output valid, rec, busy_exec, input accepted);
	modport result (input valid, rec, busy_exec, output accepted);
endinterface

//--- logic/evp_cmd_decode.sv
`include "evp_config.svh"

module evp_cmd_decode (
	input  logic clk,
	input  logic rst,
	input  logic [3:0] paddr,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic tbl_we,
	output evp_cmd_pkg::table_e tbl_wsel,
	output logic [`EVP_X_AW-1:0] tbl_waddr,
	output logic [`EVP_DATA_W-1:0] tbl_wdata,
	evp_cmd_if.decode cmd,
	input  evp_status_pkg::res_rec_t res_rec,
	input  logic [1:0] flags
);

	evp_cmd_pkg::cmd_word_u word;
	logic access;
	logic wr_cmd;
	logic op_eval;
	logic op_load;
	logic stall;
	logic complete;
	logic bad_wr;
	logic start_q;
	logic [`EVP_POLY_AW-1:0] poly_q;
	logic [`EVP_X_AW-1:0] x_addr_q;

	assign word = pwdata;
	assign access = psel & penable;
	assign wr_cmd = access & pwrite & (paddr == evp_status_pkg::REG_CMD);

	// The opcode nibble is common to both layouts
	assign op_eval = (word.eval.op == evp_cmd_pkg::OP_EVAL);
	assign op_load = (word.load.op == evp_cmd_pkg::OP_LOAD);

	// Wait state: a command write is held off until the engine is free
	assign stall = wr_cmd & (cmd.busy | start_q);
	assign pready = ~stall;
	assign complete = access & ~stall;

	assign bad_wr = pwrite & ((paddr != evp_status_pkg::REG_CMD) | ~(op_eval | op_load));
	assign pslverr = complete & bad_wr;

	// Table loads land in the cycle the transfer completes
	assign tbl_we = complete & wr_cmd & op_load;
	assign tbl_wsel = word.load.tsel;
	assign tbl_waddr = word.load.addr;
	assign tbl_wdata = word.load.value;

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			start_q <= 1'b0;
		end
		else
		begin
			start_q <= complete & wr_cmd & op_eval;
		end
	end

	always_ff @(posedge clk)
	begin
		if (complete & wr_cmd & op_eval)
		begin
			poly_q <= word.eval.poly;
			x_addr_q <= word.eval.x_addr;
		end
	end

	assign cmd.start = start_q;
	assign cmd.poly = poly_q;
	assign cmd.x_addr = x_addr_q;

	always_comb
	begin
		prdata = '0;
		if (!pwrite)
		begin
			case (paddr)
				evp_status_pkg::REG_STATUS: prdata = res_rec.status;
				evp_status_pkg::REG_RESULT: prdata = res_rec.result;
				evp_status_pkg::REG_FLAGS:  prdata = {30'd0, flags};
				default:                    prdata = '0;
			endcase
		end
	end

endmodule

//--- logic/evp_tables.sv
`include "evp_config.svh"

module evp_tables (
	input  logic clk,
	input  logic rst,
	input  logic tbl_we,
	input  evp_cmd_pkg::table_e tbl_wsel,
	input  logic [`EVP_X_AW-1:0] tbl_waddr,
	input  logic [`EVP_DATA_W-1:0] tbl_wdata,
	evp_tbl_if.tables rd
);

	logic [`EVP_DEG_W-1:0] deg_mem [0:`EVP_NUM_POLY-1];
	logic [`EVP_DATA_W-1:0] coef_mem [0:`EVP_COEF_DEPTH-1];
	logic [`EVP_DATA_W-1:0] x_mem [0:`EVP_X_DEPTH-1];
	logic deg_we;
	logic coef_we;
	logic x_we;

	assign deg_we = tbl_we & (tbl_wsel == evp_cmd_pkg::TBL_DEG) &
		(tbl_waddr < `EVP_X_AW'(`EVP_NUM_POLY));
	assign coef_we = tbl_we & (tbl_wsel == evp_cmd_pkg::TBL_COEF) &
		(tbl_waddr < `EVP_X_AW'(`EVP_COEF_DEPTH));
	assign x_we = tbl_we & (tbl_wsel == evp_cmd_pkg::TBL_X);

	// All ones marks a degree entry that software never loaded
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			for (int i = 0; i < `EVP_NUM_POLY; i++)
				deg_mem[i] <= '1;
		end
		else if (deg_we)
		begin
			deg_mem[tbl_waddr[`EVP_POLY_AW-1:0]] <= tbl_wdata[`EVP_DEG_W-1:0];
		end
	end

	always_ff @(posedge clk)
	begin
		if (rd.en_deg)
			rd.deg <= deg_mem[rd.deg_addr];
	end

	always_ff @(posedge clk)
	begin
		if (coef_we)
			coef_mem[tbl_waddr[`EVP_COEF_AW-1:0]] <= tbl_wdata;
		if (rd.en_coef)
			rd.coef <= coef_mem[rd.coef_addr];
	end

	always_ff @(posedge clk)
	begin
		if (x_we)
			x_mem[tbl_waddr] <= tbl_wdata;
		if (rd.en_x)
			rd.x <= x_mem[rd.x_addr];
	end

endmodule

//--- logic/evp_execute.sv
`include "evp_config.svh"

module evp_execute (
	input  logic clk,
	input  logic rst,
	evp_cmd_if.execute cmd,
	evp_tbl_if.execute rd,
	evp_res_if.execute res
);

	typedef enum logic [3:0] {
		S_IDLE,
		S_RD_N,
		S_CHK_N,
		S_RD_X,
		S_ACC,
		S_STEP,
		S_OUT,
		S_ERR,
		S_END
	} state_e;

	state_e state;
	state_e next_state;
	logic [`EVP_POLY_AW-1:0] poly_q;
	logic [`EVP_X_AW-1:0] x_addr_q;
	logic [3:0] n_q;
	logic [3:0] idx_q;
	logic [31:0] mono;
	logic [31:0] sum;
	logic [`EVP_COEF_AW-1:0] coef_base;
	logic bad_deg;
	evp_status_pkg::res_rec_t rec_q;

	assign coef_base = `EVP_COEF_AW'(poly_q) * `EVP_COEF_AW'(`EVP_NUM_COEF);
	assign bad_deg = (rd.deg > `EVP_DEG_W'(`EVP_NUM_COEF - 1));

	always_comb
	begin
		next_state = state;
		case (state)
			S_IDLE:  if (cmd.start) next_state = S_RD_N;
			S_RD_N:  next_state = S_CHK_N;
			S_CHK_N: next_state = bad_deg ? S_ERR : S_RD_X;
			S_RD_X:  next_state = S_ACC;
			S_ACC:   next_state = (idx_q == n_q) ? S_OUT : S_STEP;
			S_STEP:  next_state = S_ACC;
			S_OUT:   next_state = S_END;
			S_ERR:   next_state = S_END;
			S_END:   if (res.accepted) next_state = S_IDLE;
			default: next_state = S_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			state <= S_IDLE;
			idx_q <= '0;
		end
		else
		begin
			state <= next_state;
			if (state == S_IDLE)
				idx_q <= '0;
			else if (state == S_ACC && idx_q != n_q)
				idx_q <= idx_q + 4'd1;
		end
	end

	// Monomial and sum both wrap at 32 bits
	always_ff @(posedge clk)
	begin
		case (state)
			S_IDLE:
			begin
				if (cmd.start)
				begin
					poly_q <= cmd.poly;
					x_addr_q <= cmd.x_addr;
					mono <= 32'd1;
					sum <= '0;
				end
			end
			S_CHK_N: n_q <= rd.deg[3:0];
			S_ACC:   sum <= sum + mono * 32'(rd.coef);
			S_STEP:  mono <= mono * 32'(rd.x);
			S_OUT:
			begin
				rec_q.result <= sum;
				rec_q.status <= evp_status_pkg::ST_OK;
			end
			S_ERR:
			begin
				rec_q.result <= '0;
				rec_q.status <= evp_status_pkg::ST_BAD_DEG;
			end
			default: ;
		endcase
	end

	// idx already points at the next coefficient when STEP issues its read
	assign rd.en_deg = (state == S_RD_N);
	assign rd.deg_addr = poly_q;
	assign rd.en_coef = (state == S_RD_X) || (state == S_STEP);
	assign rd.coef_addr = coef_base + `EVP_COEF_AW'(idx_q);
	assign rd.en_x = (state == S_RD_X);
	assign rd.x_addr = x_addr_q;

	assign res.valid = (state == S_END);
	assign res.rec = rec_q;
	assign res.busy_exec = (state != S_IDLE);

endmodule

//--- logic/evp_result.sv
module evp_result (
	input  logic clk,
	input  logic rst,
	evp_res_if.result res,
	evp_cmd_if.result cmd,
	output evp_status_pkg::res_rec_t res_rec,
	output logic [1:0] flags
);

	logic busy_q;
	logic done_q;
	logic busy;

	// A record is only taken while a command is open
	assign res.accepted = res.valid & busy_q;

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			busy_q <= 1'b0;
			done_q <= 1'b0;
			res_rec.result <= '0;
			res_rec.status <= evp_status_pkg::ST_NONE;
		end
		else if (cmd.start)
		begin
			busy_q <= 1'b1;
			done_q <= 1'b0;
		end
		else if (res.accepted)
		begin
			busy_q <= 1'b0;
			done_q <= 1'b1;
			res_rec <= res.rec;
		end
	end

	// Busy also follows the FSM so the bus stays stalled while it runs
	assign busy = busy_q | res.busy_exec;
	assign cmd.busy = busy;
	assign flags[evp_status_pkg::FLAG_BUSY] = busy;
	assign flags[evp_status_pkg::FLAG_DONE] = done_q;

endmodule

//--- logic/evp_top.sv
`include "evp_config.svh"

module evp_top (
	input  logic clk,
	input  logic rst,
	input  logic [3:0] paddr,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr
);

	evp_cmd_if cmd_bus ();
	evp_tbl_if tbl_bus ();
	evp_res_if res_bus ();

	logic tbl_we;
	evp_cmd_pkg::table_e tbl_wsel;
	logic [`EVP_X_AW-1:0] tbl_waddr;
	logic [`EVP_DATA_W-1:0] tbl_wdata;
	evp_status_pkg::res_rec_t res_rec;
	logic [1:0] flags;

	evp_cmd_decode u_decode (
		.clk       (clk),
		.rst       (rst),
		.paddr     (paddr),
		.psel      (psel),
		.penable   (penable),
		.pwrite    (pwrite),
		.pwdata    (pwdata),
		.prdata    (prdata),
		.pready    (pready),
		.pslverr   (pslverr),
		.tbl_we    (tbl_we),
		.tbl_wsel  (tbl_wsel),
		.tbl_waddr (tbl_waddr),
		.tbl_wdata (tbl_wdata),
		.cmd       (cmd_bus.decode),
		.res_rec   (res_rec),
		.flags     (flags)
	);

	evp_tables u_tables (
		.clk       (clk),
		.rst       (rst),
		.tbl_we    (tbl_we),
		.tbl_wsel  (tbl_wsel),
		.tbl_waddr (tbl_waddr),
		.tbl_wdata (tbl_wdata),
		.rd        (tbl_bus.tables)
	);

	evp_execute u_execute (
		.clk (clk),
		.rst (rst),
		.cmd (cmd_bus.execute),
		.rd  (tbl_bus.execute),
		.res (res_bus.execute)
	);

	evp_result u_result (
		.clk     (clk),
		.rst     (rst),
		.res     (res_bus.result),
		.cmd     (cmd_bus.result),
		.res_rec (res_rec),
		.flags   (flags)
	);

endmodule

//--- dv/evp_tb.sv
`include "evp_config.svh"

module evp_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int WAIT_LIMIT = 100;
	localparam int POLL_LIMIT = 60;
	localparam int NUM_SAMPLES = 6;

	logic clk;
	logic rst;
	logic [3:0] paddr;
	logic psel;
	logic penable;
	logic pwrite;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;

	logic [15:0] lfsr_state;
	int tb_deg [0:`EVP_NUM_POLY-1];
	logic [15:0] tb_coef [0:`EVP_COEF_DEPTH-1];
	logic [15:0] tb_x [0:`EVP_X_DEPTH-1];
	logic [`EVP_X_AW-1:0] sample_addr [0:NUM_SAMPLES-1];

	evp_top dut0 (
		.clk     (clk),
		.rst     (rst),
		.paddr   (paddr),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// A command write must see pready low for as long as the engine is busy
	cmd_stall_chk: assert property (@(posedge clk) disable iff (!rst)
		(psel && penable && pwrite && paddr == evp_status_pkg::REG_CMD && dut0.flags[0])
		|-> !pready)
	else
	begin
		$display("pready rose for a CMD write while busy was high at %0t", $time);
		$display("Test failed");
		$fatal(1);
	end

	read_no_wait_chk: assert property (@(posedge clk) disable iff (!rst)
		(psel && penable && !pwrite) |-> pready)
	else
	begin
		$display("An APB read was given a wait state at %0t", $time);
		$display("Test failed");
		$fatal(1);
	end

	slverr_chk: assert property (@(posedge clk) disable iff (!rst)
		pslverr |-> (psel && penable && pready))
	else
	begin
		$display("pslverr was raised outside a completing access at %0t", $time);
		$display("Test failed");
		$fatal(1);
	end

	flags_excl_chk: assert property (@(posedge clk) disable iff (!rst)
		!(dut0.flags[0] && dut0.flags[1]))
	else
	begin
		$display("The busy and done flags were both set at %0t", $time);
		$display("Test failed");
		$fatal(1);
	end

	// Fibonacci LFSR, taps 16 14 13 11, one step per bit taken
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] val;
		logic fb;
		val = '0;
		for (int i = 0; i < n; i++)
		begin
			fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
			lfsr_state = {lfsr_state[14:0], fb};
			val = {val[30:0], fb};
		end
		return val;
	endfunction

	function automatic logic [31:0] load_word(input evp_cmd_pkg::table_e tsel, input int addr,
		input logic [15:0] value);
		return {evp_cmd_pkg::OP_LOAD, tsel, 10'(addr), value};
	endfunction

	function automatic logic [31:0] eval_word(input int poly, input logic [9:0] xaddr);
		return {evp_cmd_pkg::OP_EVAL, 3'(poly), xaddr, 15'd0};
	endfunction

	function automatic logic [31:0] model_status(input int poly);
		return (tb_deg[poly] > 10) ? evp_status_pkg::ST_BAD_DEG : evp_status_pkg::ST_OK;
	endfunction

	// Sum of c_i * x^i for i = 0..N, everything modulo 2^32
	function automatic logic [31:0] model_result(input int poly, input logic [9:0] xaddr);
		logic [31:0] mono;
		logic [31:0] sum;
		mono = 32'd1;
		sum = 32'd0;
		if (tb_deg[poly] > 10)
			return 32'd0;
		for (int i = 0; i <= tb_deg[poly]; i++)
		begin
			sum = sum + mono * {16'd0, tb_coef[poly * `EVP_NUM_COEF + i]};
			mono = mono * {16'd0, tb_x[xaddr]};
		end
		return sum;
	endfunction

	task automatic stop_with_error(input string what);
		$display("%s", what);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp)
		else
		begin
			$display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
			$display("Test failed");
			$fatal(1);
		end
	endtask

	task automatic apb_transfer(input logic write, input logic [3:0] addr,
		input logic [31:0] data, output logic [31:0] rdata, output logic err,
		output int waits);
		@(posedge clk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= write;
		paddr <= addr;
		pwdata <= data;
		@(posedge clk);
		penable <= 1'b1;
		waits = 0;
		@(negedge clk);
		while (pready !== 1'b1)
		begin
			waits++;
			if (waits > WAIT_LIMIT)
				stop_with_error($sformatf("APB transfer to offset %h never completed", addr));
			@(negedge clk);
		end
		rdata = prdata;
		err = pslverr;
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
		pwrite <= 1'b0;
	endtask

	task automatic apb_write(input logic [3:0] addr, input logic [31:0] data,
		input logic exp_err, output int waits);
		logic [31:0] rdata;
		logic err;
		apb_transfer(1'b1, addr, data, rdata, err, waits);
		check_value("pslverr", {31'd0, err}, {31'd0, exp_err});
	endtask

	task automatic expect_reg(input logic [3:0] addr, input string name,
		input logic [31:0] exp);
		logic [31:0] rdata;
		logic err;
		int waits;
		apb_transfer(1'b0, addr, 32'd0, rdata, err, waits);
		check_value("pslverr", {31'd0, err}, 32'd0);
		check_value(name, rdata, exp);
	endtask

	task automatic wait_done();
		logic [31:0] flags_v;
		logic err;
		int waits;
		int polls;
		polls = 0;
		apb_transfer(1'b0, evp_status_pkg::REG_FLAGS, 32'd0, flags_v, err, waits);
		while (flags_v[1] !== 1'b1)
		begin
			polls++;
			if (polls > POLL_LIMIT)
				stop_with_error("The done flag never set after an EVAL command");
			apb_transfer(1'b0, evp_status_pkg::REG_FLAGS, 32'd0, flags_v, err, waits);
		end
		check_value("flags.busy", {31'd0, flags_v[0]}, 32'd0);
	endtask

	task automatic issue_eval(input int poly, input logic [9:0] xaddr, output int waits);
		apb_write(evp_status_pkg::REG_CMD, eval_word(poly, xaddr), 1'b0, waits);
	endtask

	task automatic check_eval(input int poly, input logic [9:0] xaddr);
		wait_done();
		expect_reg(evp_status_pkg::REG_STATUS, "status", model_status(poly));
		expect_reg(evp_status_pkg::REG_RESULT, "result", model_result(poly, xaddr));
	endtask

	task automatic run_eval(input int poly, input logic [9:0] xaddr);
		int waits;
		issue_eval(poly, xaddr, waits);
		check_eval(poly, xaddr);
	endtask

	initial
	begin
		int waits;
		rst = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = 4'h0;
		pwdata = 32'd0;
		lfsr_state = 16'd36394;
		for (int p = 0; p < `EVP_NUM_POLY; p++)
			tb_deg[p] = 31;
		repeat (3) @(posedge clk);
		rst <= 1'b1;

		expect_reg(evp_status_pkg::REG_STATUS, "status", evp_status_pkg::ST_NONE);
		expect_reg(evp_status_pkg::REG_RESULT, "result", 32'd0);
		expect_reg(evp_status_pkg::REG_FLAGS, "flags", 32'd0);

		// Polynomials 0 and 1 pin the degree extremes, 6 stays unloaded
		for (int p = 0; p < 6; p++)
		begin
			tb_deg[p] = (p == 0) ? 10 : (p == 1) ? 0 : int'(take_bits(4) % 11);
			apb_write(evp_status_pkg::REG_CMD, load_word(evp_cmd_pkg::TBL_DEG, p,
				16'(tb_deg[p])), 1'b0, waits);
			for (int i = 0; i < `EVP_NUM_COEF; i++)
			begin
				tb_coef[p * `EVP_NUM_COEF + i] = 16'(take_bits(16));
				apb_write(evp_status_pkg::REG_CMD, load_word(evp_cmd_pkg::TBL_COEF,
					p * `EVP_NUM_COEF + i, tb_coef[p * `EVP_NUM_COEF + i]), 1'b0, waits);
			end
		end
		tb_deg[7] = 11 + int'(take_bits(5) % 20);
		apb_write(evp_status_pkg::REG_CMD, load_word(evp_cmd_pkg::TBL_DEG, 7,
			16'(tb_deg[7])), 1'b0, waits);
		for (int s = 0; s < NUM_SAMPLES; s++)
		begin
			sample_addr[s] = 10'(take_bits(10));
			tb_x[sample_addr[s]] = 16'(take_bits(16));
			apb_write(evp_status_pkg::REG_CMD, load_word(evp_cmd_pkg::TBL_X,
				int'(sample_addr[s]), tb_x[sample_addr[s]]), 1'b0, waits);
		end

		for (int p = 0; p < 6; p++)
		begin
			run_eval(p, sample_addr[p]);
			run_eval(p, sample_addr[(p + 1) % NUM_SAMPLES]);
		end

		run_eval(6, sample_addr[0]);
		run_eval(7, sample_addr[1]);

		// Second command lands while the first one is still running
		issue_eval(0, sample_addr[2], waits);
		issue_eval(2, sample_addr[3], waits);
		if (waits == 0)
			stop_with_error("A CMD write issued while busy completed without a wait state");
		check_eval(2, sample_addr[3]);

		run_eval(0, sample_addr[0]);
		apb_write(evp_status_pkg::REG_RESULT, load_word(evp_cmd_pkg::TBL_COEF, 0,
			~tb_coef[0]), 1'b1, waits);
		apb_write(evp_status_pkg::REG_STATUS, load_word(evp_cmd_pkg::TBL_DEG, 0,
			16'd31), 1'b1, waits);
		apb_write(evp_status_pkg::REG_CMD, {4'hf, 2'd1, 10'd0, ~tb_coef[0]}, 1'b1, waits);
		apb_write(evp_status_pkg::REG_CMD, {4'h0, 2'd0, 10'd0, 16'd31}, 1'b1, waits);
		expect_reg(evp_status_pkg::REG_RESULT, "result", model_result(0, sample_addr[0]));
		expect_reg(evp_status_pkg::REG_STATUS, "status", evp_status_pkg::ST_OK);
		run_eval(0, sample_addr[0]);

		$display("Test passed");
		$finish;
	end

endmodule

//--- vlog.f
+incdir+logic
logic/evp_status_pkg.sv
logic/evp_cmd_pkg.sv
logic/evp_ifs.sv
logic/evp_cmd_decode.sv
logic/evp_tables.sv
logic/evp_execute.sv
logic/evp_result.sv
logic/evp_top.sv
dv/evp_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the evp testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module evp_tb -f vlog.f -Mdir obj_dir -o evp_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/evp_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Test failed" "$LOG"; then
	exit 1
fi
if [ $run_status -ne 0 ]; then
	echo "Simulation exited with status $run_status"
	exit 1
fi
exit 0
